// ==== design/rob_pkg.sv ====
package rob_pkg;

    // Buffer geometry
    localparam int ROB_DEPTH = 16;                  // Live entries at most
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);   // Entry index, doubles as the tag
    localparam int ROB_CNT_W = ROB_IDX_W + 1;       // Occupancy 0 to ROB_DEPTH

    // Count value that means every slot is live
    localparam logic [ROB_CNT_W-1:0] ROB_FULL = ROB_CNT_W'(ROB_DEPTH);

    // Datapath widths
    localparam int XLEN   = 32;                     // Value, PC, instruction word
    localparam int PHYS_W = 7;                      // Physical register address
    localparam int ARCH_W = 5;                      // Architectural register number

    // Destination field inside the instruction word
    localparam int RD_LSB = 7;                      // rd sits at [11:7]

endpackage

// ==== design/rob_ptr_ctrl.sv ====
`timescale 1ns/1ps

module rob_ptr_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid,     // Decode offers an instruction
    output logic                          disp_ready,     // Room and no rewind this cycle
    output logic                          alloc,          // Dispatch accepted
    input  logic                          commit_pop,     // Head entry leaves
    input  logic                          br_done,
    input  logic                          br_mispredict,
    input  logic [rob_pkg::ROB_IDX_W-1:0] br_index,
    output logic [rob_pkg::ROB_IDX_W-1:0] head,           // Oldest live entry
    output logic [rob_pkg::ROB_IDX_W-1:0] tail            // Next free slot
);

    logic [rob_pkg::ROB_CNT_W-1:0] count;                // Live entries
    logic                          full;
    logic                          rewind;               // Mispredict resolved now
    logic [rob_pkg::ROB_IDX_W-1:0] br_dist;              // Branch offset from head

    assign full       = (count == rob_pkg::ROB_FULL);
    assign rewind     = br_done && br_mispredict;
    assign disp_ready = !full && !rewind;                // No dispatch during a rewind
    assign alloc      = disp_valid && disp_ready;
    assign br_dist    = br_index - head;                 // Wraps with the ring

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (commit_pop) begin
                head <= head + 1'b1;                     // Ring wraps at depth
            end
            if (rewind) begin
                tail  <= br_index + 1'b1;                // Slot just past the branch
                // Branch stays live, so the count is its distance plus one
                count <= {1'b0, br_dist} + 1'b1 - commit_pop;
            end else begin
                if (alloc) begin
                    tail <= tail + 1'b1;
                end
                count <= count + alloc - commit_pop;     // Net occupancy change
            end
        end
    end

    // Occupancy never overflows and stays in step with the pointers
    a_count_in_step: assert property (
        @(posedge clk) disable iff (rst)
        (count <= rob_pkg::ROB_FULL) &&
        (count[rob_pkg::ROB_IDX_W-1:0] == tail - head)
    ) else $error("rob_ptr_ctrl: occupancy out of step with head and tail");

    // Commit stage only drains a live entry
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) commit_pop |-> (count != '0)
    ) else $error("rob_ptr_ctrl: commit pop while empty");

endmodule

// ==== design/rob_entry_ram.sv ====
`timescale 1ns/1ps

module rob_entry_ram (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alloc,          // Write new entry at tail
    input  logic [rob_pkg::ROB_IDX_W-1:0] tail,
    input  logic [rob_pkg::XLEN-1:0]      disp_instr,
    input  logic [rob_pkg::XLEN-1:0]      disp_pc,
    input  logic                          disp_reg_write,
    input  logic                          alu_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] alu_index,
    input  logic [rob_pkg::XLEN-1:0]      alu_value,
    input  logic [rob_pkg::PHYS_W-1:0]    alu_phys,
    input  logic                          mul_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] mul_index,
    input  logic [rob_pkg::XLEN-1:0]      mul_value,
    input  logic [rob_pkg::PHYS_W-1:0]    mul_phys,
    input  logic                          div_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] div_index,
    input  logic [rob_pkg::XLEN-1:0]      div_value,
    input  logic [rob_pkg::PHYS_W-1:0]    div_phys,
    input  logic                          br_done,        // Branch resolved
    input  logic [rob_pkg::ROB_IDX_W-1:0] br_index,
    input  logic [rob_pkg::XLEN-1:0]      br_link,        // Link value of the branch
    input  logic [rob_pkg::ROB_IDX_W-1:0] head,
    input  logic                          commit_pop,     // Head consumed this cycle
    output logic                          head_ready,
    output logic [rob_pkg::XLEN-1:0]      head_value,
    output logic [rob_pkg::ARCH_W-1:0]    head_dest,
    output logic [rob_pkg::PHYS_W-1:0]    head_phys,
    output logic                          head_reg_write,
    output logic [rob_pkg::XLEN-1:0]      head_pc
);

    // Per-entry state, ready flags are the only control bits
    logic [rob_pkg::ROB_DEPTH-1:0] ready_q;
    logic [rob_pkg::ROB_DEPTH-1:0] reg_write_q;
    logic [rob_pkg::ARCH_W-1:0]    dest_q  [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::XLEN-1:0]      value_q [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::PHYS_W-1:0]    phys_q  [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::XLEN-1:0]      pc_q    [rob_pkg::ROB_DEPTH];

    logic [rob_pkg::ROB_IDX_W-1:0] live_len;             // Zero when empty or full
    logic [rob_pkg::ROB_DEPTH-1:0] stale;                // Slots outside the live window

    assign live_len = tail - head;

    // Discarded entries may have completed before the rewind.
    // Their flags are swept so the head never sees them once it wraps there.
    always_comb begin
        logic [rob_pkg::ROB_IDX_W-1:0] off;
        off   = '0;
        stale = '0;
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            off      = i[rob_pkg::ROB_IDX_W-1:0] - head; // Age rank from head
            stale[i] = (live_len != '0) && (off >= live_len);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q <= '0;
        end else begin
            ready_q <= ready_q & ~stale;                 // Later writes override
            if (alloc) begin
                ready_q[tail] <= 1'b0;                   // New entry not done
            end
            if (alu_done) begin
                ready_q[alu_index] <= 1'b1;
            end
            if (mul_done) begin
                ready_q[mul_index] <= 1'b1;
            end
            if (div_done) begin
                ready_q[div_index] <= 1'b1;
            end
            if (br_done) begin
                ready_q[br_index] <= 1'b1;
            end
            if (commit_pop) begin
                ready_q[head] <= 1'b0;                   // Slot free for reuse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            reg_write_q[tail] <= disp_reg_write;
            dest_q[tail]      <= disp_instr[rob_pkg::RD_LSB +: rob_pkg::ARCH_W]; // rd field
            pc_q[tail]        <= disp_pc;
        end
        if (alu_done) begin
            value_q[alu_index] <= alu_value;
            phys_q[alu_index]  <= alu_phys;
        end
        if (mul_done) begin
            value_q[mul_index] <= mul_value;
            phys_q[mul_index]  <= mul_phys;
        end
        if (div_done) begin
            value_q[div_index] <= div_value;
            phys_q[div_index]  <= div_phys;
        end
        if (br_done) begin
            value_q[br_index] <= br_link;                // Link goes to rd
            phys_q[br_index]  <= '0;                     // No physical target
        end
    end

    // Head entry straight to the commit stage
    assign head_ready     = ready_q[head];
    assign head_value     = value_q[head];
    assign head_dest      = dest_q[head];
    assign head_phys      = phys_q[head];
    assign head_reg_write = reg_write_q[head];
    assign head_pc        = pc_q[head];

    // Execution units never report the same tag twice in one cycle
    a_distinct_tags: assert property (
        @(posedge clk) disable iff (rst)
        !(alu_done && mul_done && alu_index == mul_index) &&
        !(alu_done && div_done && alu_index == div_index) &&
        !(mul_done && div_done && mul_index == div_index)
    ) else $error("rob_entry_ram: two completions on one index");

    // Each entry completes exactly once while live
    a_no_double_done: assert property (
        @(posedge clk) disable iff (rst)
        !(alu_done && ready_q[alu_index]) && !(mul_done && ready_q[mul_index]) &&
        !(div_done && ready_q[div_index]) && !(br_done && ready_q[br_index])
    ) else $error("rob_entry_ram: completion for an entry already ready");

endmodule

// ==== design/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       head_ready,       // Head entry has its result
    input  logic [rob_pkg::XLEN-1:0]   head_value,
    input  logic [rob_pkg::ARCH_W-1:0] head_dest,
    input  logic [rob_pkg::PHYS_W-1:0] head_phys,
    input  logic                       head_reg_write,
    input  logic [rob_pkg::XLEN-1:0]   head_pc,
    output logic                       commit_pop,       // Take the head this cycle
    output logic                       commit_valid,
    output logic [rob_pkg::XLEN-1:0]   commit_value,
    output logic [rob_pkg::ARCH_W-1:0] commit_dest,
    output logic [rob_pkg::PHYS_W-1:0] commit_phys,
    output logic                       commit_reg_write,
    output logic [rob_pkg::XLEN-1:0]   commit_pc,
    input  logic                       commit_ready      // Register file accepts
);

    // Slot free or emptied by the register file this edge
    assign commit_pop = head_ready && (!commit_valid || commit_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else if (commit_pop) begin
            commit_valid <= 1'b1;                        // Refill back to back
        end else if (commit_ready) begin
            commit_valid <= 1'b0;                        // Drained, nothing behind
        end
    end

    always_ff @(posedge clk) begin
        if (commit_pop) begin
            commit_value     <= head_value;
            commit_dest      <= head_dest;
            commit_phys      <= head_phys;
            commit_reg_write <= head_reg_write;
            commit_pc        <= head_pc;
        end
    end

    // Ready head waits unchanged in the buffer while the slot is blocked
    a_head_waits: assert property (
        @(posedge clk) disable iff (rst)
        (commit_valid && !commit_ready && head_ready) |=>
            head_ready && $stable(head_value) && $stable(head_dest) &&
            $stable(head_phys) && $stable(head_reg_write) && $stable(head_pc)
    ) else $error("rob_commit: head entry changed while the slot was blocked");

endmodule

// ==== design/rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
    input  logic                          clk,
    input  logic                          rst,
    // Dispatch from decode
    input  logic                          disp_valid,
    input  logic [rob_pkg::XLEN-1:0]      disp_instr,
    input  logic [rob_pkg::XLEN-1:0]      disp_pc,
    input  logic                          disp_reg_write,
    output logic                          disp_ready,
    output logic [rob_pkg::ROB_IDX_W-1:0] disp_index,     // Tag for issue, equals tail
    // Completion ports
    input  logic                          alu_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] alu_index,
    input  logic [rob_pkg::XLEN-1:0]      alu_value,
    input  logic [rob_pkg::PHYS_W-1:0]    alu_phys,
    input  logic                          mul_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] mul_index,
    input  logic [rob_pkg::XLEN-1:0]      mul_value,
    input  logic [rob_pkg::PHYS_W-1:0]    mul_phys,
    input  logic                          div_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] div_index,
    input  logic [rob_pkg::XLEN-1:0]      div_value,
    input  logic [rob_pkg::PHYS_W-1:0]    div_phys,
    // Branch resolution
    input  logic                          br_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0] br_index,
    input  logic [rob_pkg::XLEN-1:0]      br_link,
    input  logic                          br_mispredict,
    // Commit toward the register file
    output logic                          commit_valid,
    output logic [rob_pkg::XLEN-1:0]      commit_value,
    output logic [rob_pkg::ARCH_W-1:0]    commit_dest,
    output logic [rob_pkg::PHYS_W-1:0]    commit_phys,
    output logic                          commit_reg_write,
    output logic [rob_pkg::XLEN-1:0]      commit_pc,
    input  logic                          commit_ready
);

    logic                          alloc;                // Dispatch accepted
    logic                          commit_pop;           // Head leaves the buffer
    logic [rob_pkg::ROB_IDX_W-1:0] head;
    logic                          head_ready;
    logic [rob_pkg::XLEN-1:0]      head_value;
    logic [rob_pkg::ARCH_W-1:0]    head_dest;
    logic [rob_pkg::PHYS_W-1:0]    head_phys;
    logic                          head_reg_write;
    logic [rob_pkg::XLEN-1:0]      head_pc;

    rob_ptr_ctrl ptr_ctrl_i (
        .clk, .rst, .disp_valid, .disp_ready, .alloc, .commit_pop,
        .br_done, .br_mispredict, .br_index, .head,
        .tail (disp_index)                               // Tail doubles as the tag
    );

    rob_entry_ram entry_ram_i (
        .clk, .rst, .alloc,
        .tail (disp_index),
        .disp_instr, .disp_pc, .disp_reg_write,
        .alu_done, .alu_index, .alu_value, .alu_phys,
        .mul_done, .mul_index, .mul_value, .mul_phys,
        .div_done, .div_index, .div_value, .div_phys,
        .br_done, .br_index, .br_link, .head, .commit_pop,
        .head_ready, .head_value, .head_dest, .head_phys, .head_reg_write, .head_pc
    );

    rob_commit commit_i (
        .clk, .rst,
        .head_ready, .head_value, .head_dest, .head_phys, .head_reg_write, .head_pc,
        .commit_pop, .commit_valid, .commit_value, .commit_dest, .commit_phys,
        .commit_reg_write, .commit_pc, .commit_ready
    );

endmodule

// ==== include/rob_model.svh ====
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// One expected entry, kept in dispatch order
typedef struct {
    logic [rob_pkg::ROB_IDX_W-1:0] idx;                  // Tag given at dispatch
    logic [rob_pkg::XLEN-1:0]      value;
    logic [rob_pkg::ARCH_W-1:0]    dest;
    logic [rob_pkg::PHYS_W-1:0]    phys;
    logic                          reg_write;
    logic [rob_pkg::XLEN-1:0]      pc;
} rob_exp_t;

rob_exp_t model_q[$];                                    // Oldest at the front

function automatic void model_dispatch(input logic [rob_pkg::ROB_IDX_W-1:0] idx,
                                       input logic [rob_pkg::XLEN-1:0] instr,
                                       input logic [rob_pkg::XLEN-1:0] pc,
                                       input logic reg_write);
    rob_exp_t e;
    e.idx       = idx;
    e.value     = '0;
    e.dest      = instr[11:7];                           // rd field of a RISC-V word
    e.phys      = '0;
    e.reg_write = reg_write;
    e.pc        = pc;
    model_q.push_back(e);
endfunction

function automatic void model_complete(input logic [rob_pkg::ROB_IDX_W-1:0] idx,
                                       input logic [rob_pkg::XLEN-1:0] value,
                                       input logic [rob_pkg::PHYS_W-1:0] phys);
    foreach (model_q[k]) begin
        if (model_q[k].idx == idx) begin
            model_q[k].value = value;
            model_q[k].phys  = phys;
        end
    end
endfunction

// Branch writes its link and on a mispredict drops everything younger
function automatic void model_branch(input logic [rob_pkg::ROB_IDX_W-1:0] idx,
                                     input logic [rob_pkg::XLEN-1:0] link,
                                     input logic mispredict);
    int pos;
    pos = -1;
    foreach (model_q[k]) begin
        if (model_q[k].idx == idx) begin
            model_q[k].value = link;
            model_q[k].phys  = '0;
            pos              = k;
        end
    end
    if (mispredict && pos >= 0) begin
        model_q = model_q[0:pos];
    end
endfunction

function automatic rob_exp_t model_expect();
    return model_q[0];                                   // Next in program order
endfunction

function automatic void model_retire();
    void'(model_q.pop_front());
endfunction

`endif

// ==== test/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;

    logic                          clk;
    logic                          rst;
    logic                          disp_valid;
    logic [rob_pkg::XLEN-1:0]      disp_instr;
    logic [rob_pkg::XLEN-1:0]      disp_pc;
    logic                          disp_reg_write;
    logic                          disp_ready;
    logic [rob_pkg::ROB_IDX_W-1:0] disp_index;
    logic                          alu_done, mul_done, div_done;
    logic [rob_pkg::ROB_IDX_W-1:0] alu_index, mul_index, div_index;
    logic [rob_pkg::XLEN-1:0]      alu_value, mul_value, div_value;
    logic [rob_pkg::PHYS_W-1:0]    alu_phys, mul_phys, div_phys;
    logic                          br_done;
    logic [rob_pkg::ROB_IDX_W-1:0] br_index;
    logic [rob_pkg::XLEN-1:0]      br_link;
    logic                          br_mispredict;
    logic                          commit_valid;
    logic [rob_pkg::XLEN-1:0]      commit_value;
    logic [rob_pkg::ARCH_W-1:0]    commit_dest;
    logic [rob_pkg::PHYS_W-1:0]    commit_phys;
    logic                          commit_reg_write;
    logic [rob_pkg::XLEN-1:0]      commit_pc;
    logic                          commit_ready;

    `include "rob_model.svh"

    int errors;
    int checks;
    int tests_run;
    int commit_count;                                    // Accepted commits so far
    int test_commit_start;
    int test_err_start;
    logic rand_ready;                                    // Random back-pressure on
    logic held;                                          // Last edge saw valid without ready
    rob_exp_t held_e;                                    // Outputs seen while held
    logic [rob_pkg::XLEN-1:0] next_pc;
    logic [rob_pkg::ROB_IDX_W-1:0] tag_q[$];             // Dispatched, not yet completed

    rob_top rob_top_i (
        .clk, .rst,
        .disp_valid, .disp_instr, .disp_pc, .disp_reg_write, .disp_ready, .disp_index,
        .alu_done, .alu_index, .alu_value, .alu_phys,
        .mul_done, .mul_index, .mul_value, .mul_phys,
        .div_done, .div_index, .div_value, .div_phys,
        .br_done, .br_index, .br_link, .br_mispredict,
        .commit_valid, .commit_value, .commit_dest, .commit_phys,
        .commit_reg_write, .commit_pc, .commit_ready
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                           // 4 ns period
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Accepted commits against the model, plus hold checks under back-pressure
    always @(posedge clk) begin : compare_commits
        rob_exp_t exp_e;
        if (!rst) begin
            if (held) begin
                compare_value("commit_valid held", commit_valid, 1'b1);
                compare_value("held value", commit_value, held_e.value);
                compare_value("held dest", commit_dest, held_e.dest);
                compare_value("held phys", commit_phys, held_e.phys);
                compare_value("held reg_write", commit_reg_write, held_e.reg_write);
                compare_value("held pc", commit_pc, held_e.pc);
            end
            if (commit_valid && commit_ready) begin
                if (model_q.size() == 0) begin
                    errors++;                            // Extra or duplicated entry
                    $display("ERROR at %0t: commit arrived with no entry expected", $time);
                end else begin
                    exp_e = model_expect();
                    compare_value("commit value", commit_value, exp_e.value);
                    compare_value("commit dest", commit_dest, exp_e.dest);
                    compare_value("commit phys", commit_phys, exp_e.phys);
                    compare_value("commit reg_write", commit_reg_write, exp_e.reg_write);
                    compare_value("commit pc", commit_pc, exp_e.pc);
                    model_retire();
                end
                commit_count++;
                held = 1'b0;
            end else if (commit_valid) begin
                held             = 1'b1;                 // Must look the same next edge
                held_e.value     = commit_value;
                held_e.dest      = commit_dest;
                held_e.phys      = commit_phys;
                held_e.reg_write = commit_reg_write;
                held_e.pc        = commit_pc;
            end else begin
                held = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rand_ready) begin
            commit_ready = ($urandom % 3) != 0;          // Ready about two cycles in three
        end
    end

    initial begin
        repeat (10 + 6 * 400) @(posedge clk);            // Reset plus 400 cycles per test
        $display("Timeout: the tests did not finish within %0d cycles", 10 + 6 * 400);
        $display("Simulation failed");
        $finish;
    end

    task automatic dispatch_one(input logic reg_write, output logic [3:0] idx);
        logic [rob_pkg::XLEN-1:0] instr;
        instr          = $urandom;                       // rd lands at random
        disp_valid     = 1'b1;
        disp_instr     = instr;
        disp_pc        = next_pc;
        disp_reg_write = reg_write;
        @(posedge clk);
        while (!disp_ready) @(posedge clk);              // Held until taken
        idx = disp_index;
        model_dispatch(idx, instr, next_pc, reg_write);
        next_pc = next_pc + 4;
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic dispatch_n(input int n, input logic alt_rw);
        logic [3:0] idx;
        for (int i = 0; i < n; i++) begin
            dispatch_one(alt_rw ? i[0] : 1'b1, idx);     // Alternate starts with no write
            tag_q.push_back(idx);
        end
    endtask

    task automatic drive_port(input int port, input logic [3:0] idx);
        logic [rob_pkg::XLEN-1:0]   v;
        logic [rob_pkg::PHYS_W-1:0] p;
        v = $urandom;
        p = $urandom % 128;
        case (port)
            0: begin
                alu_done  = 1'b1;
                alu_index = idx;
                alu_value = v;
                alu_phys  = p;
            end
            1: begin
                mul_done  = 1'b1;
                mul_index = idx;
                mul_value = v;
                mul_phys  = p;
            end
            default: begin
                div_done  = 1'b1;
                div_index = idx;
                div_value = v;
                div_phys  = p;
            end
        endcase
        model_complete(idx, v, p);
    endtask

    task automatic drive_branch(input logic [3:0] idx, input logic mispredict);
        logic [rob_pkg::XLEN-1:0] link;
        link          = $urandom;
        br_done       = 1'b1;
        br_index      = idx;
        br_link       = link;
        br_mispredict = mispredict;
        model_branch(idx, link, mispredict);
    endtask

    task automatic end_strobes();
        @(negedge clk);
        alu_done      = 1'b0;                            // One-cycle strobes
        mul_done      = 1'b0;
        div_done      = 1'b0;
        br_done       = 1'b0;
        br_mispredict = 1'b0;
    endtask

    // Shuffle pending tags, then complete up to max_per_cycle per cycle
    task automatic complete_tags(input int max_per_cycle);
        int j;
        int k;
        int off;
        logic [3:0] tmp;
        for (int i = tag_q.size() - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = tag_q[i];
            tag_q[i] = tag_q[j];
            tag_q[j] = tmp;
        end
        while (tag_q.size() != 0) begin
            k   = 1 + ($urandom % max_per_cycle);
            off = $urandom % 3;                          // Random first port
            if (k > tag_q.size()) k = tag_q.size();
            for (int i = 0; i < k; i++) drive_port((off + i) % 3, tag_q.pop_front());
            end_strobes();
            if ($urandom % 4 == 0) @(negedge clk);       // Idle gap now and then
        end
    endtask

    task automatic begin_test();
        test_commit_start = commit_count;
        test_err_start    = errors;
    endtask

    task automatic finish_test(input string name, input int expected);
        while (model_q.size() != 0) @(negedge clk);      // Watchdog bounds this
        @(negedge clk);
        compare_value({name, " commit count"}, commit_count - test_commit_start, expected);
        compare_value({name, " commit_valid idle"}, commit_valid, 1'b0);
        tests_run++;
        $display("test %0d %s finished, %0d errors", tests_run, name, errors - test_err_start);
    endtask

    task automatic test_branch_rewind();
        logic [3:0] bt[7];
        logic [3:0] new_idx;
        logic [3:0] exp_idx;
        begin_test();
        dispatch_n(7, 1'b0);
        foreach (bt[i]) bt[i] = tag_q.pop_front();
        drive_port(0, bt[0]);
        drive_port(1, bt[2]);
        drive_port(2, bt[5]);                            // Younger, done before the rewind
        end_strobes();
        drive_branch(bt[1], 1'b0);                       // Predicted correctly
        end_strobes();
        drive_branch(bt[3], 1'b1);
        end_strobes();
        exp_idx = bt[3] + 1'b1;
        dispatch_one(1'b1, new_idx);
        compare_value("index after rewind", new_idx, exp_idx);
        tag_q.push_back(new_idx);
        complete_tags(1);
        finish_test("branch rewind", 5);
    endtask

    initial begin
        void'($urandom(32'ha40a));
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp_instr     = '0;
        disp_pc        = '0;
        disp_reg_write = 1'b0;
        alu_done       = 1'b0;
        alu_index      = '0;
        alu_value      = '0;
        alu_phys       = '0;
        mul_done       = 1'b0;
        mul_index      = '0;
        mul_value      = '0;
        mul_phys       = '0;
        div_done       = 1'b0;
        div_index      = '0;
        div_value      = '0;
        div_phys       = '0;
        br_done        = 1'b0;
        br_index       = '0;
        br_link        = '0;
        br_mispredict  = 1'b0;
        commit_ready   = 1'b1;
        rand_ready     = 1'b0;
        held           = 1'b0;
        next_pc        = 32'h0000_1000;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        compare_value("commit_valid after reset", commit_valid, 1'b0);
        compare_value("disp_ready after reset", disp_ready, 1'b1);
        compare_value("disp_index after reset", disp_index, '0);

        begin_test();
        dispatch_n(8, 1'b0);
        complete_tags(1);                                // One per cycle, any port
        finish_test("random order", 8);

        begin_test();
        dispatch_n(6, 1'b0);
        drive_port(0, tag_q[5]);                         // All three ports at once
        drive_port(1, tag_q[3]);
        drive_port(2, tag_q[1]);
        end_strobes();
        drive_port(2, tag_q[0]);
        drive_port(0, tag_q[4]);
        drive_port(1, tag_q[2]);
        end_strobes();
        tag_q.delete();
        finish_test("same cycle completions", 6);

        begin_test();
        commit_ready = 1'b0;
        dispatch_n(16, 1'b0);
        repeat (3) begin
            compare_value("disp_ready when full", disp_ready, 1'b0);
            @(negedge clk);
        end
        complete_tags(3);
        commit_ready = 1'b1;
        while (model_q.size() != 0) @(negedge clk);      // Drain before reusing tags
        compare_value("disp_ready after drain", disp_ready, 1'b1);
        dispatch_n(3, 1'b0);
        complete_tags(2);
        finish_test("full buffer", 19);

        begin_test();
        rand_ready = 1'b1;
        dispatch_n(6, 1'b0);
        complete_tags(2);
        dispatch_n(6, 1'b0);
        complete_tags(3);
        while (model_q.size() != 0) @(negedge clk);
        rand_ready   = 1'b0;
        commit_ready = 1'b1;
        finish_test("back-pressure", 12);

        test_branch_rewind();

        begin_test();
        dispatch_n(6, 1'b1);                             // reg_write 0,1,0,1,...
        complete_tags(2);
        finish_test("no reg write", 6);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
design/rob_pkg.sv
design/rob_ptr_ctrl.sv
design/rob_entry_ram.sv
design/rob_commit.sv
design/rob_top.sv
test/rob_tb.sv
